// File: common/dma_defines.svh
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Cluster size
`define DMA_CORE_COUNT 4
`define DMA_SLOT_COUNT 8
`define DMA_CORE_NO_W 2
`define DMA_SLOT_NO_W 3

// Address map
`define DMA_CORE_ADDR_W 16
`define DMA_ADDR_W 18
`define DMA_SLOT_LEAD_ZERO 8
`define DMA_SLOT_ADDR_W 7
`define DMA_RX_OFFSET 8'h0A

// Packet length
`define DMA_LEN_W 16
`define DMA_MAX_LEN_RST 1024

// FIFO depths in pointer bits
`define DMA_SLOT_FIFO_DEPTH_W 5
`define DMA_TRIG_FIFO_DEPTH_W 3

`endif

// File: common/dma_pkg.sv
`include "dma_defines.svh"

package dma_pkg;

  // Slot identity
  typedef logic [`DMA_CORE_NO_W-1:0] core_no_t;
  typedef logic [`DMA_SLOT_NO_W-1:0] slot_no_t;

  // Slot base address without its low zero bits
  typedef logic [`DMA_SLOT_ADDR_W-1:0] slot_addr_t;

  // Core number on top of the core-local address
  typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;

  typedef logic [`DMA_LEN_W-1:0] pkt_len_t;

  // AXI write side and the core message word
  typedef logic [63:0] axi_data_t;
  typedef logic [7:0] axi_id_t;
  typedef logic [1:0] axi_resp_t;

endpackage

// File: design/desc_fifo.sv
module desc_fifo #(
  parameter int DEPTH_W = 4,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] din,
  input  logic             din_valid,
  output logic             din_ready,
  output logic [WIDTH-1:0] dout,
  output logic             dout_valid,
  input  logic             dout_ready
);

  logic [WIDTH-1:0] mem [0:(2**DEPTH_W)-1];
  logic [DEPTH_W-1:0] wr_ptr;
  logic [DEPTH_W-1:0] rd_ptr;
  logic [DEPTH_W:0] count;
  logic push;
  logic pop;

  assign din_ready = (count != (DEPTH_W+1)'(2**DEPTH_W));
  assign dout_valid = (count != '0);
  assign dout = mem[rd_ptr];

  assign push = din_valid && din_ready;
  assign pop = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: rx_path/rx_slot_issuer.sv
`include "dma_defines.svh"

module rx_slot_issuer import dma_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  core_no_t                   inject_core,
  input  slot_no_t                   inject_slot,
  input  logic                       inject_valid,
  output logic                       inject_ready,
  input  core_no_t                   recycle_core,
  input  slot_no_t                   recycle_slot,
  input  logic                       recycle_valid,
  input  slot_no_t                   slot_addr_wr_no,
  input  slot_addr_t                 slot_addr_wr_data,
  input  logic                       slot_addr_wr_valid,
  input  logic [`DMA_CORE_COUNT-1:0] drop_list,
  input  logic                       drop_list_valid,
  input  pkt_len_t                   max_pkt_len,
  input  logic                       max_pkt_len_valid,
  input  logic                       incoming_pkt_ready,
  output dma_addr_t                  rx_desc_addr,
  output pkt_len_t                   rx_desc_len,
  output logic                       rx_desc_valid,
  input  logic                       rx_desc_ready,
  output core_no_t                   trig_core,
  output slot_no_t                   trig_slot,
  output slot_addr_t                 trig_slot_addr,
  output logic                       trig_valid,
  output logic                       err_slot_overflow
);

  logic slot_fifo_din_ready;
  logic slot_fifo_dout_valid;
  logic [`DMA_CORE_NO_W+`DMA_SLOT_NO_W-1:0] slot_fifo_dout;
  core_no_t head_core;
  slot_no_t head_slot;

  slot_addr_t slot_addr_mem [0:`DMA_SLOT_COUNT-1];
  logic [`DMA_CORE_COUNT-1:0] drop_r;
  pkt_len_t max_len_r;

  logic stg_valid;
  core_no_t stg_core;
  slot_no_t stg_slot;
  slot_addr_t stg_slot_addr;
  logic stg_drop;
  logic stg_load;
  logic rx_xfer;
  logic [7:0] pkt_credit;

  // Recycled slots have no back-pressure, so they always win
  assign inject_ready = !recycle_valid && slot_fifo_din_ready;

  desc_fifo #(
    .DEPTH_W(`DMA_SLOT_FIFO_DEPTH_W),
    .WIDTH(`DMA_CORE_NO_W + `DMA_SLOT_NO_W)
  ) i_slot_fifo (
    .clk(clk),
    .rst(rst),
    .din(recycle_valid ? {recycle_core, recycle_slot} : {inject_core, inject_slot}),
    .din_valid(recycle_valid || inject_valid),
    .din_ready(slot_fifo_din_ready),
    .dout(slot_fifo_dout),
    .dout_valid(slot_fifo_dout_valid),
    .dout_ready(stg_load)
  );

  assign {head_core, head_slot} = slot_fifo_dout;

  always_ff @(posedge clk) begin
    if (slot_addr_wr_valid) begin
      slot_addr_mem[slot_addr_wr_no] <= slot_addr_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_r <= '0;
      max_len_r <= pkt_len_t'(`DMA_MAX_LEN_RST);
      err_slot_overflow <= 1'b0;
    end else begin
      if (drop_list_valid) begin
        drop_r <= drop_list;
      end
      if (max_pkt_len_valid) begin
        max_len_r <= max_pkt_len;
      end
      if (recycle_valid && !slot_fifo_din_ready) begin
        err_slot_overflow <= 1'b1;
      end
    end
  end

  // One-entry lookup stage
  assign stg_drop = stg_valid && drop_r[stg_core];
  assign stg_load = !stg_valid || stg_drop || rx_xfer;

  always_ff @(posedge clk) begin
    if (rst) begin
      stg_valid <= 1'b0;
    end else if (stg_load) begin
      stg_valid <= slot_fifo_dout_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (stg_load && slot_fifo_dout_valid) begin
      stg_core <= head_core;
      stg_slot <= head_slot;
      stg_slot_addr <= slot_addr_mem[head_slot];
    end
  end

  // Announced packets not yet matched by a descriptor
  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_credit <= '0;
    end else if (incoming_pkt_ready && !rx_xfer) begin
      pkt_credit <= pkt_credit + 1'b1;
    end else if (rx_xfer && !incoming_pkt_ready) begin
      pkt_credit <= pkt_credit - 1'b1;
    end
  end

  assign rx_desc_valid = stg_valid && !drop_r[stg_core] &&
                         ((pkt_credit != '0) || incoming_pkt_ready);
  assign rx_xfer = rx_desc_valid && rx_desc_ready;

  assign rx_desc_addr = {stg_core, 1'b0, stg_slot_addr, `DMA_RX_OFFSET};
  assign rx_desc_len = max_len_r;

  assign trig_core = stg_core;
  assign trig_slot = stg_slot;
  assign trig_slot_addr = stg_slot_addr;
  assign trig_valid = rx_xfer;

endmodule

// File: rx_path/trigger_writer.sv
`include "dma_defines.svh"

module trigger_writer import dma_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  core_no_t   trig_core,
  input  slot_no_t   trig_slot,
  input  slot_addr_t trig_slot_addr,
  input  logic       trig_valid,
  input  logic       pkt_sent_to_core_valid,
  input  pkt_len_t   pkt_sent_to_core_len,
  output axi_id_t    awid,
  output dma_addr_t  awaddr,
  output logic       awvalid,
  input  logic       awready,
  output axi_data_t  wdata,
  output logic       wvalid,
  input  logic       wready,
  input  axi_resp_t  bresp,
  input  logic       bvalid,
  output logic       err_write_resp
);

  logic trig_fifo_din_ready;
  logic trig_fifo_dout_valid;
  logic [`DMA_CORE_NO_W+`DMA_SLOT_NO_W+`DMA_SLOT_ADDR_W-1:0] trig_fifo_dout;
  core_no_t head_core;
  slot_no_t head_slot;
  slot_addr_t head_slot_addr;
  logic [7:0] deliver_cnt;
  logic start;

  desc_fifo #(
    .DEPTH_W(`DMA_TRIG_FIFO_DEPTH_W),
    .WIDTH(`DMA_CORE_NO_W + `DMA_SLOT_NO_W + `DMA_SLOT_ADDR_W)
  ) i_trig_fifo (
    .clk(clk),
    .rst(rst),
    .din({trig_core, trig_slot, trig_slot_addr}),
    .din_valid(trig_valid),
    .din_ready(trig_fifo_din_ready),
    .dout(trig_fifo_dout),
    .dout_valid(trig_fifo_dout_valid),
    .dout_ready(start)
  );

  assign {head_core, head_slot, head_slot_addr} = trig_fifo_dout;

  // Both channels must be done before the next notice
  assign start = trig_fifo_dout_valid && !awvalid && !wvalid &&
                 ((deliver_cnt != '0) || pkt_sent_to_core_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      deliver_cnt <= '0;
    end else if (pkt_sent_to_core_valid && !start) begin
      deliver_cnt <= deliver_cnt + 1'b1;
    end else if (start && !pkt_sent_to_core_valid) begin
      deliver_cnt <= deliver_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      awvalid <= 1'b0;
      wvalid <= 1'b0;
    end else if (start) begin
      awvalid <= 1'b1;
      wvalid <= 1'b1;
    end else begin
      if (awvalid && awready) begin
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
      end
    end
  end

  // Notice lands in the trigger area of the target core
  always_ff @(posedge clk) begin
    if (start) begin
      awid <= axi_id_t'(head_core);
      awaddr <= {head_core, {(`DMA_CORE_ADDR_W-9){1'b0}}, 1'b1,
                 {(5-`DMA_SLOT_NO_W){1'b0}}, head_slot, 3'b000};
      wdata <= {8'd0,
                {(24-`DMA_SLOT_LEAD_ZERO-`DMA_SLOT_ADDR_W){1'b0}}, head_slot_addr,
                {`DMA_SLOT_LEAD_ZERO{1'b0}},
                {(8-`DMA_SLOT_NO_W){1'b0}}, head_slot,
                8'd0,
                pkt_sent_to_core_len};
    end
  end

  // A trigger lost to a full FIFO is a missing write too
  always_ff @(posedge clk) begin
    if (rst) begin
      err_write_resp <= 1'b0;
    end else if ((bvalid && (bresp != 2'b00)) || (trig_valid && !trig_fifo_din_ready)) begin
      err_write_resp <= 1'b1;
    end
  end

endmodule

// File: design/tx_msg_decoder.sv
`include "dma_defines.svh"

module tx_msg_decoder import dma_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  axi_data_t msg_data,
  input  core_no_t  msg_core_no,
  input  logic      msg_valid,
  output logic      msg_ready,
  output dma_addr_t tx_desc_addr,
  output pkt_len_t  tx_desc_len,
  output logic      tx_desc_valid,
  input  logic      tx_desc_ready,
  input  logic      pkt_sent_out_valid,
  output core_no_t  recycle_core,
  output slot_no_t  recycle_slot,
  output logic      recycle_valid
);

  logic msg_xfer;
  pkt_len_t msg_len;

  assign msg_ready = !tx_desc_valid;
  assign msg_xfer = msg_valid && msg_ready;
  assign msg_len = msg_data[`DMA_LEN_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_desc_valid <= 1'b0;
      recycle_valid <= 1'b0;
    end else begin
      if (tx_desc_valid && tx_desc_ready) begin
        tx_desc_valid <= 1'b0;
      end else if (msg_xfer) begin
        // Zero length means the core dropped the packet
        tx_desc_valid <= (msg_len != '0);
      end
      recycle_valid <= pkt_sent_out_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (msg_xfer) begin
      tx_desc_addr <= {msg_core_no, msg_data[32 +: `DMA_CORE_ADDR_W]};
      tx_desc_len <= msg_len;
    end
    if (msg_xfer && (msg_len != '0)) begin
      recycle_core <= msg_core_no;
      recycle_slot <= msg_data[24 +: `DMA_SLOT_NO_W];
    end
  end

endmodule

// File: design/dma_controller.sv
`include "dma_defines.svh"

module dma_controller import dma_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  core_no_t                   inject_core,
  input  slot_no_t                   inject_slot,
  input  logic                       inject_valid,
  output logic                       inject_ready,
  input  slot_no_t                   slot_addr_wr_no,
  input  slot_addr_t                 slot_addr_wr_data,
  input  logic                       slot_addr_wr_valid,
  input  logic [`DMA_CORE_COUNT-1:0] drop_list,
  input  logic                       drop_list_valid,
  input  pkt_len_t                   max_pkt_len,
  input  logic                       max_pkt_len_valid,
  input  logic                       incoming_pkt_ready,
  output dma_addr_t                  rx_desc_addr,
  output pkt_len_t                   rx_desc_len,
  output logic                       rx_desc_valid,
  input  logic                       rx_desc_ready,
  input  logic                       pkt_sent_to_core_valid,
  input  pkt_len_t                   pkt_sent_to_core_len,
  output axi_id_t                    awid,
  output dma_addr_t                  awaddr,
  output logic                       awvalid,
  input  logic                       awready,
  output axi_data_t                  wdata,
  output logic                       wvalid,
  input  logic                       wready,
  input  axi_resp_t                  bresp,
  input  logic                       bvalid,
  input  axi_data_t                  msg_data,
  input  core_no_t                   msg_core_no,
  input  logic                       msg_valid,
  output logic                       msg_ready,
  output dma_addr_t                  tx_desc_addr,
  output pkt_len_t                   tx_desc_len,
  output logic                       tx_desc_valid,
  input  logic                       tx_desc_ready,
  input  logic                       pkt_sent_out_valid,
  output logic                       err_slot_overflow,
  output logic                       err_write_resp
);

  // Issued slots heading for the trigger writer
  core_no_t trig_core;
  slot_no_t trig_slot;
  slot_addr_t trig_slot_addr;
  logic trig_valid;

  // Sent slots returning to the slot FIFO
  core_no_t recycle_core;
  slot_no_t recycle_slot;
  logic recycle_valid;

  rx_slot_issuer i_rx_slot_issuer (
    .clk(clk),
    .rst(rst),
    .inject_core(inject_core),
    .inject_slot(inject_slot),
    .inject_valid(inject_valid),
    .inject_ready(inject_ready),
    .recycle_core(recycle_core),
    .recycle_slot(recycle_slot),
    .recycle_valid(recycle_valid),
    .slot_addr_wr_no(slot_addr_wr_no),
    .slot_addr_wr_data(slot_addr_wr_data),
    .slot_addr_wr_valid(slot_addr_wr_valid),
    .drop_list(drop_list),
    .drop_list_valid(drop_list_valid),
    .max_pkt_len(max_pkt_len),
    .max_pkt_len_valid(max_pkt_len_valid),
    .incoming_pkt_ready(incoming_pkt_ready),
    .rx_desc_addr(rx_desc_addr),
    .rx_desc_len(rx_desc_len),
    .rx_desc_valid(rx_desc_valid),
    .rx_desc_ready(rx_desc_ready),
    .trig_core(trig_core),
    .trig_slot(trig_slot),
    .trig_slot_addr(trig_slot_addr),
    .trig_valid(trig_valid),
    .err_slot_overflow(err_slot_overflow)
  );

  trigger_writer i_trigger_writer (
    .clk(clk),
    .rst(rst),
    .trig_core(trig_core),
    .trig_slot(trig_slot),
    .trig_slot_addr(trig_slot_addr),
    .trig_valid(trig_valid),
    .pkt_sent_to_core_valid(pkt_sent_to_core_valid),
    .pkt_sent_to_core_len(pkt_sent_to_core_len),
    .awid(awid),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .err_write_resp(err_write_resp)
  );

  tx_msg_decoder i_tx_msg_decoder (
    .clk(clk),
    .rst(rst),
    .msg_data(msg_data),
    .msg_core_no(msg_core_no),
    .msg_valid(msg_valid),
    .msg_ready(msg_ready),
    .tx_desc_addr(tx_desc_addr),
    .tx_desc_len(tx_desc_len),
    .tx_desc_valid(tx_desc_valid),
    .tx_desc_ready(tx_desc_ready),
    .pkt_sent_out_valid(pkt_sent_out_valid),
    .recycle_core(recycle_core),
    .recycle_slot(recycle_slot),
    .recycle_valid(recycle_valid)
  );

endmodule

// File: tests/tb_dma_controller.sv
`include "dma_defines.svh"

module tb_dma_controller import dma_pkg::*; ();

  typedef enum logic [3:0] {
    k_slot_addr, k_max_len, k_drop, k_inject, k_incoming,
    k_deliver, k_msg, k_sent, k_bresp
  } row_kind_t;

  // len doubles as slot address, drop mask, pulse count or bresp
  typedef struct packed {
    row_kind_t kind;
    core_no_t core;
    slot_no_t slot;
    pkt_len_t len;
    logic [7:0] exp_rx;
    logic exp_err;
  } row_t;

  typedef struct packed {
    core_no_t core;
    slot_no_t slot;
    slot_addr_t saddr;
  } slot_ent_t;

  typedef struct packed {
    axi_id_t id;
    dma_addr_t addr;
  } aw_exp_t;

  typedef struct packed {
    dma_addr_t addr;
    pkt_len_t len;
  } tx_exp_t;

  logic clk;
  logic rst;
  core_no_t inject_core;
  slot_no_t inject_slot;
  logic inject_valid;
  logic inject_ready;
  slot_no_t slot_addr_wr_no;
  slot_addr_t slot_addr_wr_data;
  logic slot_addr_wr_valid;
  logic [`DMA_CORE_COUNT-1:0] drop_list;
  logic drop_list_valid;
  pkt_len_t max_pkt_len;
  logic max_pkt_len_valid;
  logic incoming_pkt_ready;
  dma_addr_t rx_desc_addr;
  pkt_len_t rx_desc_len;
  logic rx_desc_valid;
  logic rx_desc_ready;
  logic pkt_sent_to_core_valid;
  pkt_len_t pkt_sent_to_core_len;
  axi_id_t awid;
  dma_addr_t awaddr;
  logic awvalid;
  logic awready;
  axi_data_t wdata;
  logic wvalid;
  logic wready;
  axi_resp_t bresp;
  logic bvalid;
  axi_data_t msg_data;
  core_no_t msg_core_no;
  logic msg_valid;
  logic msg_ready;
  dma_addr_t tx_desc_addr;
  pkt_len_t tx_desc_len;
  logic tx_desc_valid;
  logic tx_desc_ready;
  logic pkt_sent_out_valid;
  logic err_slot_overflow;
  logic err_write_resp;

  // Reference model state
  row_t rows[$];
  slot_ent_t rx_q[$];
  slot_ent_t trig_q[$];
  aw_exp_t aw_q[$];
  axi_data_t w_q[$];
  tx_exp_t tx_q[$];
  slot_addr_t slot_addr_ref [0:`DMA_SLOT_COUNT-1];
  logic [`DMA_CORE_COUNT-1:0] drop_ref;
  pkt_len_t max_len_ref;
  core_no_t last_tx_core;
  slot_no_t last_tx_slot;
  int rx_count;
  int cycle_count;
  int cycle_limit;
  logic [31:0] ready_state;
  logic [31:0] gap_state;
  slot_ent_t rx_e;
  aw_exp_t aw_e;
  axi_data_t w_e;
  tx_exp_t tx_e;

  dma_controller i_dut (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Core, one zero bit, slot address, receive offset
  function automatic dma_addr_t rx_addr_of(input slot_ent_t e);
    return (dma_addr_t'(e.core) << `DMA_CORE_ADDR_W) | (dma_addr_t'(e.saddr) << 8) |
           dma_addr_t'(`DMA_RX_OFFSET);
  endfunction

  function automatic dma_addr_t trig_addr_of(input core_no_t core, input slot_no_t slot);
    return (dma_addr_t'(core) << `DMA_CORE_ADDR_W) | dma_addr_t'(18'h100) |
           (dma_addr_t'(slot) << 3);
  endfunction

  function automatic axi_data_t notice_word_of(input pkt_len_t len, input slot_no_t slot,
                                               input slot_addr_t saddr);
    return axi_data_t'(len) | (axi_data_t'(slot) << 24) |
           (axi_data_t'(saddr) << (32 + `DMA_SLOT_LEAD_ZERO));
  endfunction

  task automatic check(input logic ok, input string what);
    assert (ok) else begin
      $display("CHECK FAILED at time %0t: %s", $time, what);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic add_row(input row_kind_t kind, input int core, input int slot,
                         input int len, input int exp_rx, input bit exp_err);
    row_t r;
    r.kind = kind;
    r.core = core_no_t'(core);
    r.slot = slot_no_t'(slot);
    r.len = pkt_len_t'(len);
    r.exp_rx = 8'(exp_rx);
    r.exp_err = exp_err;
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(k_slot_addr, 0, 0, 'h11, 0, 0);
    add_row(k_slot_addr, 0, 1, 'h22, 0, 0);
    add_row(k_slot_addr, 0, 2, 'h33, 0, 0);
    add_row(k_slot_addr, 0, 3, 'h44, 0, 0);
    add_row(k_max_len, 0, 0, 1500, 0, 0);
    // No credit yet, so nothing issues
    add_row(k_inject, 0, 0, 0, 0, 0);
    add_row(k_inject, 1, 1, 0, 0, 0);
    add_row(k_incoming, 0, 0, 2, 2, 0);
    add_row(k_deliver, 0, 0, 64, 2, 0);
    add_row(k_deliver, 0, 0, 128, 2, 0);
    // Credit ahead of the slots
    add_row(k_incoming, 0, 0, 2, 2, 0);
    add_row(k_inject, 2, 2, 0, 3, 0);
    add_row(k_inject, 3, 3, 0, 4, 0);
    add_row(k_deliver, 0, 0, 200, 4, 0);
    add_row(k_deliver, 0, 0, 300, 4, 0);
    add_row(k_drop, 0, 0, 'b0100, 4, 0);
    add_row(k_incoming, 0, 0, 3, 4, 0);
    add_row(k_inject, 2, 0, 0, 4, 0);
    add_row(k_inject, 1, 2, 0, 5, 0);
    add_row(k_inject, 3, 1, 0, 6, 0);
    add_row(k_inject, 2, 3, 0, 6, 0);
    add_row(k_inject, 0, 3, 0, 7, 0);
    add_row(k_deliver, 0, 0, 11, 7, 0);
    add_row(k_deliver, 0, 0, 22, 7, 0);
    add_row(k_deliver, 0, 0, 33, 7, 0);
    add_row(k_msg, 1, 5, 90, 7, 0);
    add_row(k_msg, 3, 4, 0, 7, 0);
    add_row(k_slot_addr, 0, 5, 'h55, 7, 0);
    add_row(k_incoming, 0, 0, 1, 7, 0);
    add_row(k_sent, 0, 0, 0, 8, 0);
    add_row(k_deliver, 0, 0, 77, 8, 0);
    add_row(k_msg, 2, 6, 40, 8, 0);
    add_row(k_bresp, 0, 0, 2, 8, 1);
    add_row(k_incoming, 0, 0, 1, 8, 1);
    add_row(k_inject, 0, 1, 0, 9, 1);
    add_row(k_deliver, 0, 0, 55, 9, 1);
  endtask

  task automatic apply_row(input row_t r, input int idx);
    slot_ent_t ent;
    logic [15:0] msg_addr;
    case (r.kind)
      k_slot_addr: begin
        slot_addr_wr_no = r.slot;
        slot_addr_wr_data = slot_addr_t'(r.len);
        slot_addr_wr_valid = 1'b1;
        slot_addr_ref[r.slot] = slot_addr_t'(r.len);
        @(negedge clk);
        slot_addr_wr_valid = 1'b0;
      end
      k_max_len: begin
        max_pkt_len = r.len;
        max_pkt_len_valid = 1'b1;
        max_len_ref = r.len;
        @(negedge clk);
        max_pkt_len_valid = 1'b0;
      end
      k_drop: begin
        drop_list = r.len[`DMA_CORE_COUNT-1:0];
        drop_list_valid = 1'b1;
        drop_ref = r.len[`DMA_CORE_COUNT-1:0];
        @(negedge clk);
        drop_list_valid = 1'b0;
      end
      k_inject: begin
        if (!drop_ref[r.core]) begin
          ent.core = r.core;
          ent.slot = r.slot;
          ent.saddr = slot_addr_ref[r.slot];
          rx_q.push_back(ent);
        end
        inject_core = r.core;
        inject_slot = r.slot;
        inject_valid = 1'b1;
        @(posedge clk);
        while (!inject_ready) @(posedge clk);
        @(negedge clk);
        inject_valid = 1'b0;
      end
      k_incoming: begin
        repeat (r.len) begin
          incoming_pkt_ready = 1'b1;
          @(negedge clk);
          incoming_pkt_ready = 1'b0;
          @(negedge clk);
        end
      end
      k_deliver: begin
        check(trig_q.size() > 0, "delivery row has no issued slot to notify");
        ent = trig_q.pop_front();
        aw_q.push_back({axi_id_t'(ent.core), trig_addr_of(ent.core, ent.slot)});
        w_q.push_back(notice_word_of(r.len, ent.slot, ent.saddr));
        // Length stays until the next delivery
        pkt_sent_to_core_len = r.len;
        pkt_sent_to_core_valid = 1'b1;
        @(negedge clk);
        pkt_sent_to_core_valid = 1'b0;
      end
      k_msg: begin
        msg_addr = 16'h4000 | (16'(r.slot) << 8) | 16'(idx);
        msg_data = '0;
        msg_data[15:0] = r.len;
        msg_data[31:24] = 8'(r.slot);
        msg_data[47:32] = msg_addr;
        msg_core_no = r.core;
        if (r.len != 0) begin
          tx_q.push_back({(dma_addr_t'(r.core) << 16) | dma_addr_t'(msg_addr), r.len});
          last_tx_core = r.core;
          last_tx_slot = r.slot;
        end
        msg_valid = 1'b1;
        @(posedge clk);
        while (!msg_ready) @(posedge clk);
        @(negedge clk);
        msg_valid = 1'b0;
      end
      k_sent: begin
        if (!drop_ref[last_tx_core]) begin
          ent.core = last_tx_core;
          ent.slot = last_tx_slot;
          ent.saddr = slot_addr_ref[last_tx_slot];
          rx_q.push_back(ent);
        end
        pkt_sent_out_valid = 1'b1;
        @(negedge clk);
        pkt_sent_out_valid = 1'b0;
      end
      default: begin
        bresp = axi_resp_t'(r.len);
        bvalid = 1'b1;
        @(negedge clk);
        bvalid = 1'b0;
        bresp = 2'b00;
      end
    endcase
  endtask

  task automatic wait_settled(input row_t r);
    while (rx_count < r.exp_rx || aw_q.size() != 0 || w_q.size() != 0 || tx_q.size() != 0)
      @(negedge clk);
    // Quiet period catches extra descriptors
    repeat (4) @(negedge clk);
    check(rx_count == r.exp_rx,
          $sformatf("%0d receive descriptors, expected %0d", rx_count, r.exp_rx));
    check(err_write_resp == r.exp_err,
          $sformatf("err_write_resp %b, expected %b", err_write_resp, r.exp_err));
  endtask

  always @(negedge clk) begin
    ready_state = xorshift(ready_state);
    awready = ready_state[2];
    wready = ready_state[7];
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      check(err_slot_overflow == 1'b0, "err_slot_overflow is set");
      if (rx_desc_valid && rx_desc_ready) begin
        check(rx_q.size() > 0, "receive descriptor with none expected");
        rx_e = rx_q.pop_front();
        check(rx_desc_addr == rx_addr_of(rx_e) && rx_desc_len == max_len_ref,
              $sformatf("rx desc %h/%0d, expected %h/%0d", rx_desc_addr, rx_desc_len,
                        rx_addr_of(rx_e), max_len_ref));
        trig_q.push_back(rx_e);
        rx_count = rx_count + 1;
      end
      if (awvalid && awready) begin
        check(aw_q.size() > 0, "AXI write address with none expected");
        aw_e = aw_q.pop_front();
        check(awid == aw_e.id && awaddr == aw_e.addr,
              $sformatf("aw %h/%h, expected %h/%h", awid, awaddr, aw_e.id, aw_e.addr));
      end
      if (wvalid && wready) begin
        check(w_q.size() > 0, "AXI write data with none expected");
        w_e = w_q.pop_front();
        check(wdata == w_e, $sformatf("wdata %h, expected %h", wdata, w_e));
      end
      if (tx_desc_valid && tx_desc_ready) begin
        check(tx_q.size() > 0, "transmit descriptor with none expected");
        tx_e = tx_q.pop_front();
        check(tx_desc_addr == tx_e.addr && tx_desc_len == tx_e.len,
              $sformatf("tx desc %h/%0d, expected %h/%0d", tx_desc_addr, tx_desc_len,
                        tx_e.addr, tx_e.len));
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    inject_core = '0;
    inject_slot = '0;
    inject_valid = 1'b0;
    slot_addr_wr_no = '0;
    slot_addr_wr_data = '0;
    slot_addr_wr_valid = 1'b0;
    drop_list = '0;
    drop_list_valid = 1'b0;
    max_pkt_len = '0;
    max_pkt_len_valid = 1'b0;
    incoming_pkt_ready = 1'b0;
    rx_desc_ready = 1'b1;
    pkt_sent_to_core_valid = 1'b0;
    pkt_sent_to_core_len = '0;
    awready = 1'b0;
    wready = 1'b0;
    bresp = 2'b00;
    bvalid = 1'b0;
    msg_data = '0;
    msg_core_no = '0;
    msg_valid = 1'b0;
    tx_desc_ready = 1'b1;
    pkt_sent_out_valid = 1'b0;
    drop_ref = '0;
    max_len_ref = pkt_len_t'(`DMA_MAX_LEN_RST);
    last_tx_core = '0;
    last_tx_slot = '0;
    rx_count = 0;
    cycle_count = 0;
    ready_state = 32'd19;
    gap_state = 32'd19;
    build_table();
    cycle_limit = 200 * rows.size();
    repeat (4) @(negedge clk);
    rst = 1'b0;
    check(!rx_desc_valid && !tx_desc_valid && !awvalid && !wvalid,
          "a valid output is high after reset");
    check(!err_slot_overflow && !err_write_resp, "an error flag is set after reset");
    check(rx_desc_len == max_len_ref,
          $sformatf("rx_desc_len %0d after reset, expected %0d", rx_desc_len, max_len_ref));
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(rows[i], i);
      wait_settled(rows[i]);
      gap_state = xorshift(gap_state);
      repeat (gap_state % 3) @(negedge clk);
    end
    check(rx_q.size() == 0 && trig_q.size() == 0, "issued slots left over at the end");
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+common
common/dma_pkg.sv
design/desc_fifo.sv
rx_path/rx_slot_issuer.sv
rx_path/trigger_writer.sv
design/tx_msg_decoder.sv
design/dma_controller.sv
tests/tb_dma_controller.sv
